//--- rtl/multipu_pkg.sv
//##########################################################
// pi1 op codes and the accumulator ISA shared by the cluster.
// opcode sits in the top OPCODE_W bits of a word.
//##########################################################

package multipu_pkg;

	// pi1 op field.
	localparam logic [1:0] PI1_NOOP = 2'b00;
	localparam logic [1:0] PI1_WROP = 2'b01;
	localparam logic [1:0] PI1_RDOP = 2'b10;

	localparam int OPCODE_W = 4;

	// unknown opcodes are treated as halt.
	localparam logic [OPCODE_W-1:0] OP_HALT  = 4'h0;
	localparam logic [OPCODE_W-1:0] OP_LOAD  = 4'h1;
	localparam logic [OPCODE_W-1:0] OP_ADD   = 4'h2;
	localparam logic [OPCODE_W-1:0] OP_STORE = 4'h3;
	localparam logic [OPCODE_W-1:0] OP_ADDID = 4'h4;

	// ceiling log2, 0 for an input of 1.
	function automatic int clog2(input int value);
		int result;
		int remain;
		result = 0;
		remain = value - 1;
		while (remain > 0) begin
			result = result + 1;
			remain = remain >> 1;
		end
		return result;
	endfunction

endpackage

//--- rtl/pu.sv
//##########################################################
// accumulator unit, one pi1 transfer outstanding at most.
// halt is final until the next reset.
//##########################################################

`timescale 1ns/1ps

module pu #(

	 parameter int ARCHBITSZ = 32

	,localparam int ADDRBITSZ = ARCHBITSZ - multipu_pkg::clog2(ARCHBITSZ/8)
	,localparam int SELBITSZ  = ARCHBITSZ/8

) (

	 input  logic clk_i
	,input  logic rst_n_i

	,output logic [1:0]           pi1_op_o
	,output logic [ADDRBITSZ-1:0] pi1_addr_o
	,output logic [ARCHBITSZ-1:0] pi1_data_o
	,input  logic [ARCHBITSZ-1:0] pi1_data_i
	,output logic [SELBITSZ-1:0]  pi1_sel_o
	,input  logic                 pi1_rdy_i

	,output logic halted_o

	,input  logic [ADDRBITSZ-1:0] rstaddr_i
	,input  logic [ARCHBITSZ-1:0] id_i
);

localparam int OPNDBITSZ = ADDRBITSZ - multipu_pkg::OPCODE_W;

typedef enum logic [1:0] {
	ST_FETCH,
	ST_EXEC_MEM,
	ST_EXEC,
	ST_HALTED
} state_t;

state_t state_q;

logic [ADDRBITSZ-1:0] pc_q;
logic [ADDRBITSZ-1:0] pc_nxt;
logic [ARCHBITSZ-1:0] acc_q;
logic [ARCHBITSZ-1:0] ir_q;

logic [1:0]           op_q;
logic [ADDRBITSZ-1:0] addr_q;
logic [ARCHBITSZ-1:0] wdata_q;

logic [multipu_pkg::OPCODE_W-1:0] fetch_opc;
logic [multipu_pkg::OPCODE_W-1:0] ir_opc;
logic [ADDRBITSZ-1:0]             fetch_opnd;
logic                             fetch_mem;

// decode straight off the bus so the operand transfer starts on the fetch edge.
assign fetch_opc  = pi1_data_i[ARCHBITSZ-1 -: multipu_pkg::OPCODE_W];
assign fetch_opnd = ADDRBITSZ'(pi1_data_i[OPNDBITSZ-1:0]);
assign fetch_mem  = (fetch_opc == multipu_pkg::OP_LOAD) ||
	(fetch_opc == multipu_pkg::OP_ADD) ||
	(fetch_opc == multipu_pkg::OP_STORE);

assign ir_opc = ir_q[ARCHBITSZ-1 -: multipu_pkg::OPCODE_W];
assign pc_nxt = pc_q + ADDRBITSZ'(1);

always_ff @(posedge clk_i or negedge rst_n_i) begin
	if (!rst_n_i) begin
		state_q <= ST_FETCH;
		pc_q    <= rstaddr_i;
		acc_q   <= '0;
		op_q    <= multipu_pkg::PI1_NOOP;
	end else begin
		case (state_q)
			ST_FETCH: begin
				if (op_q == multipu_pkg::PI1_NOOP) begin
					op_q <= multipu_pkg::PI1_RDOP; // first fetch after reset.
				end else if (pi1_rdy_i) begin
					if (fetch_mem) begin
						state_q <= ST_EXEC_MEM;
						op_q    <= (fetch_opc == multipu_pkg::OP_STORE) ?
							multipu_pkg::PI1_WROP : multipu_pkg::PI1_RDOP;
					end else begin
						state_q <= ST_EXEC;
						op_q    <= multipu_pkg::PI1_NOOP;
					end
				end
			end
			ST_EXEC_MEM: begin
				if (pi1_rdy_i) begin
					if (ir_opc == multipu_pkg::OP_LOAD)
						acc_q <= pi1_data_i;
					else if (ir_opc == multipu_pkg::OP_ADD)
						acc_q <= acc_q + pi1_data_i; // wraps.
					pc_q    <= pc_nxt;
					op_q    <= multipu_pkg::PI1_RDOP; // next fetch right away.
					state_q <= ST_FETCH;
				end
			end
			ST_EXEC: begin
				if (ir_opc == multipu_pkg::OP_ADDID) begin
					acc_q   <= acc_q + id_i;
					pc_q    <= pc_nxt;
					op_q    <= multipu_pkg::PI1_RDOP;
					state_q <= ST_FETCH;
				end else begin
					state_q <= ST_HALTED;
				end
			end
			default: begin
				state_q <= ST_HALTED; // parked.
			end
		endcase
	end
end

// instruction and request payload.
always_ff @(posedge clk_i) begin
	case (state_q)
		ST_FETCH: begin
			if (op_q == multipu_pkg::PI1_NOOP) begin
				addr_q <= pc_q;
			end else if (pi1_rdy_i) begin
				ir_q    <= pi1_data_i;
				addr_q  <= fetch_opnd;
				wdata_q <= acc_q; // only used by store.
			end
		end
		ST_EXEC_MEM: begin
			if (pi1_rdy_i)
				addr_q <= pc_nxt;
		end
		ST_EXEC: begin
			addr_q <= pc_nxt;
		end
		default: begin
			addr_q <= addr_q;
		end
	endcase
end

assign pi1_op_o   = op_q;
assign pi1_addr_o = addr_q;
assign pi1_data_o = wdata_q;
assign pi1_sel_o  = '1; // whole words only.

assign halted_o = (state_q == ST_HALTED);

endmodule

//--- rtl/pi1q.sv
//##########################################################
// round-robin pi1 arbiter, drive to the slave is registered.
// masters must hold requests until their rdy.
//##########################################################

`timescale 1ns/1ps

module pi1q #(

	 parameter int PUCOUNT   = 2
	,parameter int ARCHBITSZ = 32

	,localparam int ADDRBITSZ = ARCHBITSZ - multipu_pkg::clog2(ARCHBITSZ/8)
	,localparam int SELBITSZ  = ARCHBITSZ/8

) (

	 input  logic clk_i
	,input  logic rst_n_i

	,input  logic [PUCOUNT-1:0][1:0]           m_op_i
	,input  logic [PUCOUNT-1:0][ADDRBITSZ-1:0] m_addr_i
	,input  logic [PUCOUNT-1:0][ARCHBITSZ-1:0] m_data_i
	,input  logic [PUCOUNT-1:0][SELBITSZ-1:0]  m_sel_i
	,output logic [PUCOUNT-1:0][ARCHBITSZ-1:0] m_data_o
	,output logic [PUCOUNT-1:0]                m_rdy_o

	,output logic [1:0]           s_op_o
	,output logic [ADDRBITSZ-1:0] s_addr_o
	,output logic [ARCHBITSZ-1:0] s_data_o
	,output logic [SELBITSZ-1:0]  s_sel_o
	,input  logic [ARCHBITSZ-1:0] s_data_i
	,input  logic                 s_rdy_i
);

localparam int GNTBITSZ = (PUCOUNT > 1) ? multipu_pkg::clog2(PUCOUNT) : 1;

logic [GNTBITSZ-1:0]  gnt_q;
logic [1:0]           s_op_q;
logic [ADDRBITSZ-1:0] s_addr_q;
logic [ARCHBITSZ-1:0] s_data_q;
logic [SELBITSZ-1:0]  s_sel_q;

logic                busy;
logic                done;
logic                load;
logic                nxt_vld;
logic [GNTBITSZ-1:0] nxt_gnt;

assign busy = (s_op_q != multipu_pkg::PI1_NOOP);
assign done = busy && s_rdy_i;
assign load = done || !busy;

// search starts after the current grant, which comes last.
always_comb begin
	int cand;
	nxt_vld = 1'b0;
	nxt_gnt = gnt_q;
	cand    = 0;
	for (int k = 1; k <= PUCOUNT; k++) begin
		cand = (int'(gnt_q) + k) % PUCOUNT;
		// the finishing master still shows its old request this cycle.
		if (!nxt_vld && (m_op_i[cand] != multipu_pkg::PI1_NOOP) &&
			!(done && (k == PUCOUNT))) begin
			nxt_vld = 1'b1;
			nxt_gnt = GNTBITSZ'(cand);
		end
	end
end

always_ff @(posedge clk_i or negedge rst_n_i) begin
	if (!rst_n_i) begin
		gnt_q  <= GNTBITSZ'(PUCOUNT-1); // so master 0 goes first.
		s_op_q <= multipu_pkg::PI1_NOOP;
	end else if (load) begin
		if (nxt_vld) begin
			gnt_q  <= nxt_gnt;
			s_op_q <= m_op_i[nxt_gnt];
		end else begin
			s_op_q <= multipu_pkg::PI1_NOOP; // park.
		end
	end
end

always_ff @(posedge clk_i) begin
	if (load && nxt_vld) begin
		s_addr_q <= m_addr_i[nxt_gnt];
		s_data_q <= m_data_i[nxt_gnt];
		s_sel_q  <= m_sel_i[nxt_gnt];
	end
end

assign s_op_o   = s_op_q;
assign s_addr_o = s_addr_q;
assign s_data_o = s_data_q;
assign s_sel_o  = s_sel_q;

// read data goes to everyone, rdy only to the owner of the bus.
genvar i;
generate for (i = 0; i < PUCOUNT; i = i + 1) begin : gen_resp
	assign m_data_o[i] = s_data_i;
	assign m_rdy_o[i]  = done && (gnt_q == GNTBITSZ'(i));
end endgenerate

endmodule

//--- rtl/multipu.sv
//##########################################################
// PUCOUNT units sharing one pi1 bus on clk_i.
// unit 0 boots from rstaddr_i, the rest from rstaddr2_i.
//##########################################################

`timescale 1ns/1ps

module multipu #(

	 parameter int PUCOUNT   = 2
	,parameter int ARCHBITSZ = 32

	,localparam int ADDRBITSZ = ARCHBITSZ - multipu_pkg::clog2(ARCHBITSZ/8)
	,localparam int SELBITSZ  = ARCHBITSZ/8

) (

	 input  logic clk_i
	,input  logic rst_n_i

	,output logic [1:0]           pi1_op_o
	,output logic [ADDRBITSZ-1:0] pi1_addr_o
	,output logic [ARCHBITSZ-1:0] pi1_data_o
	,input  logic [ARCHBITSZ-1:0] pi1_data_i
	,output logic [SELBITSZ-1:0]  pi1_sel_o
	,input  logic                 pi1_rdy_i

	,output logic [PUCOUNT-1:0] halted_o

	,input  logic [ADDRBITSZ-1:0] rstaddr_i
	,input  logic [ADDRBITSZ-1:0] rstaddr2_i

	,input  logic [ARCHBITSZ-1:0] id_i
);

// master side of the arbiter, one slot per unit.
logic [PUCOUNT-1:0][1:0]           m_op_w;
logic [PUCOUNT-1:0][ADDRBITSZ-1:0] m_addr_w;
logic [PUCOUNT-1:0][ARCHBITSZ-1:0] m_wdata_w;
logic [PUCOUNT-1:0][ARCHBITSZ-1:0] m_rdata_w;
logic [PUCOUNT-1:0][SELBITSZ-1:0]  m_sel_w;
logic [PUCOUNT-1:0]                m_rdy_w;

pi1q #(

	 .PUCOUNT   (PUCOUNT)
	,.ARCHBITSZ (ARCHBITSZ)

) pi1q (

	 .clk_i   (clk_i)
	,.rst_n_i (rst_n_i)

	,.m_op_i   (m_op_w)
	,.m_addr_i (m_addr_w)
	,.m_data_i (m_wdata_w)
	,.m_sel_i  (m_sel_w)
	,.m_data_o (m_rdata_w)
	,.m_rdy_o  (m_rdy_w)

	,.s_op_o   (pi1_op_o)
	,.s_addr_o (pi1_addr_o)
	,.s_data_o (pi1_data_o)
	,.s_sel_o  (pi1_sel_o)
	,.s_data_i (pi1_data_i)
	,.s_rdy_i  (pi1_rdy_i)
);

genvar i;
generate for (i = 0; i < PUCOUNT; i = i + 1) begin : gen_pu
	pu #(

		 .ARCHBITSZ (ARCHBITSZ)

	) pu (

		 .clk_i   (clk_i)
		,.rst_n_i (rst_n_i)

		,.pi1_op_o   (m_op_w[i])
		,.pi1_addr_o (m_addr_w[i])
		,.pi1_data_o (m_wdata_w[i])
		,.pi1_data_i (m_rdata_w[i])
		,.pi1_sel_o  (m_sel_w[i])
		,.pi1_rdy_i  (m_rdy_w[i])

		,.halted_o (halted_o[i])

		,.rstaddr_i ((i == 0) ? rstaddr_i : rstaddr2_i)

		,.id_i (id_i + ARCHBITSZ'(i)) // consecutive ids.
	);
end endgenerate

endmodule

//--- verif/tb_clkgen.sv
//##########################################################
// free running clock, reset low for RST_CYCLES rising edges.
//##########################################################

`timescale 1ns/1ps

module tb_clkgen #(
	 parameter int PERIOD_NS  = 40
	,parameter int RST_CYCLES = 16
) (
	 output logic clk_o
	,output logic rst_n_o
);

initial begin
	clk_o = 1'b0;
	forever #(PERIOD_NS/2) clk_o = ~clk_o;
end

initial begin
	int n;
	rst_n_o = 1'b0;
	for (n = 0; n < RST_CYCLES; n++)
		@(posedge clk_o);
	rst_n_o <= 1'b1; // released on a rising edge.
end

endmodule

//--- verif/pi1_mem_model.sv
//##########################################################
// pi1 word memory that reloads from image_i while in reset.
// rdy stalls at random and bus rule violations raise bus_err_o.
//##########################################################

`timescale 1ns/1ps

module pi1_mem_model #(
	 parameter int ARCHBITSZ = 32
	,parameter int ADDRBITSZ = 30
	,parameter int DEPTH     = 256
	,parameter int IDXBITSZ  = 8
) (
	 input  logic clk_i
	,input  logic rst_n_i

	,input  logic [1:0]             op_i
	,input  logic [ADDRBITSZ-1:0]   addr_i
	,input  logic [ARCHBITSZ-1:0]   data_i
	,input  logic [ARCHBITSZ/8-1:0] sel_i
	,output logic [ARCHBITSZ-1:0]   data_o
	,output logic                   rdy_o

	,input  logic [ARCHBITSZ-1:0] image_i [0:DEPTH-1]
	,output logic                 bus_err_o
);

logic [ARCHBITSZ-1:0] mem [0:DEPTH-1];

int seed = 82464;

logic [IDXBITSZ-1:0]    idx;
logic                   in_range;
logic [1:0]             prev_op;
logic [ADDRBITSZ-1:0]   prev_addr;
logic [ARCHBITSZ-1:0]   prev_data;
logic [ARCHBITSZ/8-1:0] prev_sel;
logic                   prev_stall;

assign idx      = addr_i[IDXBITSZ-1:0];
assign in_range = (addr_i < ADDRBITSZ'(DEPTH));

always @(posedge clk_i or negedge rst_n_i) begin
	int coin;
	if (!rst_n_i) begin
		for (int a = 0; a < DEPTH; a++)
			mem[a] = image_i[a];
		rdy_o  <= 1'b0;
		data_o <= '0;
	end else if (rdy_o && (op_i != multipu_pkg::PI1_NOOP)) begin
		if (op_i == multipu_pkg::PI1_WROP)
			mem[idx] = data_i;
		rdy_o <= 1'b0; // transfer ends on this edge.
	end else if (op_i != multipu_pkg::PI1_NOOP) begin
		coin = $random(seed);
		if (coin[0]) begin
			rdy_o  <= 1'b1;
			data_o <= mem[idx];
		end
	end
end

// protocol monitor.
always @(posedge clk_i or negedge rst_n_i) begin
	if (!rst_n_i) begin
		prev_stall <= 1'b0;
		bus_err_o  <= 1'b0;
	end else begin
		if (prev_stall) begin
			assert ((op_i == prev_op) && (addr_i === prev_addr) &&
				(data_i === prev_data) && (sel_i === prev_sel))
			else begin
				$display("Mismatch at %0d ns: request changed while rdy was low", $time);
				bus_err_o <= 1'b1;
			end
		end
		if (op_i != multipu_pkg::PI1_NOOP) begin
			assert (sel_i == '1)
			else begin
				$display("Mismatch at %0d ns: sel is %h, expected all ones", $time, sel_i);
				bus_err_o <= 1'b1;
			end
			assert (in_range)
			else begin
				$display("pi1 request for word %0h lies outside the memory model", addr_i);
				bus_err_o <= 1'b1;
			end
		end
		prev_stall <= (op_i != multipu_pkg::PI1_NOOP) && !rdy_o;
		prev_op    <= op_i;
		prev_addr  <= addr_i;
		prev_data  <= data_i;
		prev_sel   <= sel_i;
	end
end

endmodule

//--- verif/tb_multipu.sv
//##########################################################
// two units run on disjoint data and run_ref predicts memory.
//##########################################################

`timescale 1ns/1ps

module tb_multipu;

localparam int PUCOUNT   = 2;
localparam int ARCHBITSZ = 32;
localparam int ADDRBITSZ = ARCHBITSZ - multipu_pkg::clog2(ARCHBITSZ/8);
localparam int DEPTH     = 256;
localparam int IDXBITSZ  = 8;

localparam int RST_TIMEOUT  = 64;
localparam int HALT_TIMEOUT = 4000;
localparam int QUIET_CYCLES = 50;

localparam logic [IDXBITSZ-1:0]  BOOT0    = 8'h00;
localparam logic [IDXBITSZ-1:0]  BOOT1    = 8'h40;
localparam logic [IDXBITSZ-1:0]  ID_SLOT0 = 8'h88;
localparam logic [IDXBITSZ-1:0]  ID_SLOT1 = 8'h98;
localparam logic [ARCHBITSZ-1:0] BASE_ID  = 32'h1234_5670;

logic                   clk;
logic                   rst_n;
logic [1:0]             pi1_op;
logic [ADDRBITSZ-1:0]   pi1_addr;
logic [ARCHBITSZ-1:0]   pi1_wdata;
logic [ARCHBITSZ-1:0]   pi1_rdata;
logic [ARCHBITSZ/8-1:0] pi1_sel;
logic                   pi1_rdy;
logic [PUCOUNT-1:0]     halted;
logic [PUCOUNT-1:0]     halted_q;
logic [ADDRBITSZ-1:0]   rstaddr;
logic [ADDRBITSZ-1:0]   rstaddr2;
logic [ARCHBITSZ-1:0]   id;
logic                   bus_err;
logic                   halt_seen = 1'b0;
logic                   cmp_done = 1'b0;

logic [ARCHBITSZ-1:0] boot_img [0:DEPTH-1];
logic [ARCHBITSZ-1:0] ref_mem  [0:DEPTH-1];

tb_clkgen #(.PERIOD_NS(40), .RST_CYCLES(16)) clkgen (.clk_o(clk), .rst_n_o(rst_n));

pi1_mem_model #(
	 .ARCHBITSZ (ARCHBITSZ)
	,.ADDRBITSZ (ADDRBITSZ)
	,.DEPTH     (DEPTH)
	,.IDXBITSZ  (IDXBITSZ)
) mem_model (
	 .clk_i     (clk)
	,.rst_n_i   (rst_n)
	,.op_i      (pi1_op)
	,.addr_i    (pi1_addr)
	,.data_i    (pi1_wdata)
	,.sel_i     (pi1_sel)
	,.data_o    (pi1_rdata)
	,.rdy_o     (pi1_rdy)
	,.image_i   (boot_img)
	,.bus_err_o (bus_err)
);

multipu #(.PUCOUNT(PUCOUNT), .ARCHBITSZ(ARCHBITSZ)) UUT (
	 .clk_i      (clk)
	,.rst_n_i    (rst_n)
	,.pi1_op_o   (pi1_op)
	,.pi1_addr_o (pi1_addr)
	,.pi1_data_o (pi1_wdata)
	,.pi1_data_i (pi1_rdata)
	,.pi1_sel_o  (pi1_sel)
	,.pi1_rdy_i  (pi1_rdy)
	,.halted_o   (halted)
	,.rstaddr_i  (rstaddr)
	,.rstaddr2_i (rstaddr2)
	,.id_i       (id)
);

task automatic abort_run(input string why);
	$display("%s", why);
	$display("Simulation finished: FAIL");
	$fatal(1);
endtask

function automatic logic [ARCHBITSZ-1:0] instr(input logic [3:0] opc,
	input logic [IDXBITSZ-1:0] opnd);
	return {opc, 20'h0, opnd};
endfunction

// background words that are all distinct.
function automatic logic [ARCHBITSZ-1:0] fill_word(input logic [IDXBITSZ-1:0] a);
	return {a, ~a, a ^ 8'h5A, ~(a ^ 8'h5A)};
endfunction

// runs the accumulator ISA and returns 1 once the program halts.
function automatic bit run_ref(input logic [IDXBITSZ-1:0] start,
	input logic [ARCHBITSZ-1:0] uid);
	logic [IDXBITSZ-1:0]  pc;
	logic [ARCHBITSZ-1:0] acc;
	logic [ARCHBITSZ-1:0] ins;
	logic [IDXBITSZ-1:0]  opnd;
	int step;
	pc  = start;
	acc = '0;
	for (step = 0; step < 64; step++) begin
		ins  = ref_mem[pc];
		opnd = ins[IDXBITSZ-1:0];
		case (ins[ARCHBITSZ-1 -: 4])
			multipu_pkg::OP_LOAD:  acc = ref_mem[opnd];
			multipu_pkg::OP_ADD:   acc = acc + ref_mem[opnd];
			multipu_pkg::OP_STORE: ref_mem[opnd] = acc;
			multipu_pkg::OP_ADDID: acc = acc + uid;
			default:               return 1'b1;
		endcase
		pc = pc + 8'd1;
	end
	return 1'b0;
endfunction

task automatic build_image();
	int a;
	for (a = 0; a < DEPTH; a++)
		boot_img[a] = fill_word(a[IDXBITSZ-1:0]);
	// unit 0 carries out of bit 31 in the add.
	boot_img[8'h00] = instr(multipu_pkg::OP_ADDID, 8'h00);
	boot_img[8'h01] = instr(multipu_pkg::OP_STORE, ID_SLOT0);
	boot_img[8'h02] = instr(multipu_pkg::OP_LOAD,  8'h80);
	boot_img[8'h03] = instr(multipu_pkg::OP_ADD,   8'h81);
	boot_img[8'h04] = instr(multipu_pkg::OP_STORE, 8'h89);
	boot_img[8'h05] = instr(multipu_pkg::OP_ADD,   8'h82);
	boot_img[8'h06] = instr(multipu_pkg::OP_ADD,   8'h82);
	boot_img[8'h07] = instr(multipu_pkg::OP_STORE, 8'h8A);
	boot_img[8'h08] = instr(multipu_pkg::OP_HALT,  8'h00);
	// unit 1 ends on an undefined opcode.
	boot_img[8'h40] = instr(multipu_pkg::OP_ADDID, 8'h00);
	boot_img[8'h41] = instr(multipu_pkg::OP_STORE, ID_SLOT1);
	boot_img[8'h42] = instr(multipu_pkg::OP_LOAD,  8'h90);
	boot_img[8'h43] = instr(multipu_pkg::OP_ADD,   8'h91);
	boot_img[8'h44] = instr(multipu_pkg::OP_ADD,   8'h91);
	boot_img[8'h45] = instr(multipu_pkg::OP_STORE, 8'h99);
	boot_img[8'h46] = instr(multipu_pkg::OP_LOAD,  8'h92);
	boot_img[8'h47] = instr(multipu_pkg::OP_STORE, 8'h9A);
	boot_img[8'h48] = instr(4'hF, 8'h00);
	boot_img[8'h80] = 32'hFFFF_FFF0;
	boot_img[8'h81] = 32'h0000_0025;
	boot_img[8'h82] = 32'h8000_0001;
	boot_img[8'h90] = 32'h7FFF_FFFF;
	boot_img[8'h91] = 32'h8000_0000;
	boot_img[8'h92] = 32'hDEAD_BEEF;
endtask

always @(negedge clk) begin
	assert (!bus_err) else abort_run("the memory model saw an illegal pi1 request");
	if (rst_n === 1'b1) begin
		assert ((halted & halted_q) == halted_q)
		else abort_run($sformatf("Mismatch at %0d ns: halted_o fell from %b to %b",
			$time, halted_q, halted));
	end
	halted_q <= (rst_n === 1'b1) ? halted : '0;
end

initial begin
	int a;
	int cyc;
	logic [PUCOUNT-1:0] exp_halted;
	rstaddr  <= ADDRBITSZ'(BOOT0);
	rstaddr2 <= ADDRBITSZ'(BOOT1);
	id       <= BASE_ID;
	build_image();
	for (a = 0; a < DEPTH; a++)
		ref_mem[a] = boot_img[a];
	// data regions are disjoint, so one shared copy is enough.
	exp_halted[0] = run_ref(BOOT0, BASE_ID);
	exp_halted[1] = run_ref(BOOT1, BASE_ID + 32'd1);

	// last pass runs in the first cycle after release.
	cyc = 0;
	while (rst_n !== 1'b1) begin
		@(negedge clk);
		cyc++;
		assert ((pi1_op == multipu_pkg::PI1_NOOP) && (halted == '0))
		else abort_run($sformatf("Mismatch at %0d ns: op %0d halted %b around reset",
			$time, pi1_op, halted));
		assert (cyc < RST_TIMEOUT) else abort_run("reset was never released");
	end

	cyc = 0;
	while (halted != exp_halted) begin
		@(negedge clk);
		cyc++;
		assert (cyc < HALT_TIMEOUT)
		else abort_run($sformatf("timed out waiting for the units to halt, halted is %b",
			halted));
	end
	halt_seen = 1'b1;

	for (cyc = 0; cyc < QUIET_CYCLES; cyc++) begin
		@(negedge clk);
		assert (pi1_op == multipu_pkg::PI1_NOOP)
		else abort_run($sformatf("Mismatch at %0d ns: op %0d after all units halted",
			$time, pi1_op));
	end

	cyc = 0;
	while (!cmp_done) begin
		@(negedge clk);
		cyc++;
		assert (cyc < RST_TIMEOUT) else abort_run("memory compare never finished");
	end
	$display("Simulation finished: PASS");
	$finish;
end

initial begin : compare_results
	int a;
	int cyc;
	logic [ARCHBITSZ-1:0] diff;
	cyc = 0;
	while (!halt_seen) begin
		@(negedge clk);
		cyc++;
		assert (cyc < HALT_TIMEOUT + RST_TIMEOUT)
		else abort_run("compare process gave up waiting for the halts");
	end
	for (a = 0; a < DEPTH; a++) begin
		assert (mem_model.mem[a] === ref_mem[a])
		else abort_run($sformatf("Mismatch at %0d ns: word %02h is %08h, expected %08h",
			$time, a, mem_model.mem[a], ref_mem[a]));
	end
	diff = mem_model.mem[ID_SLOT1] - mem_model.mem[ID_SLOT0];
	assert (diff == 32'd1)
	else abort_run($sformatf("Mismatch at %0d ns: unit ids differ by %0d, expected 1",
		$time, diff));
	cmp_done = 1'b1;
end

endmodule

//--- multipu.f
rtl/multipu_pkg.sv
rtl/pu.sv
rtl/pi1q.sv
rtl/multipu.sv
verif/tb_clkgen.sv
verif/pi1_mem_model.sv
verif/tb_multipu.sv

//--- run_sim.sh
#!/bin/sh
# builds tb_multipu with Verilator and runs it, the log decides pass or fail.

rm -rf obj_dir sim.log

{ verilator --binary --timing --assert -f multipu.f --top-module tb_multipu -o tb_multipu \
	&& ./obj_dir/tb_multipu ; } > sim.log 2>&1 \
	|| echo "Simulation finished: FAIL" >> sim.log

cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0
